// File: fpu_rnd_macros.svh
// shared widths, limits, special patterns and rounding codes; include in RTL and testbench

`ifndef FPU_RND_MACROS_SVH
`define FPU_RND_MACROS_SVH

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

`define FRACT_W 28 // producer fraction incl. {r,s}
`define ALIGN_W 35 // align shifter word
`define EXP_W   10 // exponent with signed headroom
`define SHIFT_W 5  // shift amount

`define EXP_MAX 10'd254 // largest finite biased exponent

////////////////////////////////////////////////////////////
// special value magnitudes, sign goes on top
////////////////////////////////////////////////////////////

`define INF_BITS  31'h7f80_0000
`define QNAN_BITS 31'h7fc0_0000
`define SNAN_BITS 31'h7fbf_ffff // quiet bit clear, payload all ones

// rounding modes, rmode_i encoding
`define RM_NEAREST 2'b00
`define RM_TO_ZERO 2'b01
`define RM_TO_INFP 2'b10
`define RM_TO_INFM 2'b11

`endif

// File: fpu_rnd_pkg.sv
// types shared by the rounding back end stages and by the producers that drive it

`include "fpu_rnd_macros.svh"

package fpu_rnd_pkg;

  ////////////////////////////////////////////////////////////
  // producer inputs
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                ready;     // one-cycle strobe
    logic                sign;
    logic                sub_0;     // subtraction with exact zero result
    logic [`SHIFT_W-1:0] shl;
    logic [`EXP_W-1:0]   exp_shl;   // exponent if left shifted
    logic [`EXP_W-1:0]   exp_sh0;   // exponent if not shifted
    logic [`FRACT_W-1:0] fract;     // carry at msb, {r,s} at lsbs
    logic                inv;
    logic                inf;
    logic                snan;
    logic                qnan;
    logic                anan_sign; // sign of a NaN result
  } addsub_src_t;

  typedef struct packed {
    logic                ready;
    logic                sign;
    logic [`SHIFT_W-1:0] shr;
    logic                shl;       // single bit left shift
    logic [`EXP_W-1:0]   exp_shr;
    logic [`EXP_W-1:0]   exp_shl;
    logic [`EXP_W-1:0]   exp_sh0;
    logic [`FRACT_W-1:0] fract;
    logic                inv;
    logic                inf;
    logic                snan;
    logic                qnan;
    logic                anan_sign;
  } mul_src_t;

  typedef struct packed {
    logic                ready;
    logic                sign;
    logic [23:0]         int24;     // integer part before align
    logic [`SHIFT_W-1:0] shr;
    logic [3:0]          shl;
    logic                ovf;       // out of int32 range
    logic                snan;
  } f2i_src_t;

  ////////////////////////////////////////////////////////////
  // stage outputs
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic              sign;
    logic [`EXP_W-1:0] exp;
    logic [31:0]       fract;
    logic [1:0]        rs;        // round, sticky
    logic              inv;
    logic              inf;
    logic              snan;
    logic              qnan;
    logic              anan_sign;
    logic              ovf;       // f2i overflow
    logic              is_int;    // f2i operation
  } aligned_t;

  typedef struct packed {
    logic              sign;
    logic [`EXP_W-1:0] exp;
    logic [31:0]       fract;     // after increment
    logic              lost;      // any bit dropped
    logic              inv;
    logic              inf;
    logic              snan;
    logic              qnan;
    logic              anan_sign;
    logic              ovf;
    logic              is_int;
  } rounded_t;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] mant;
  } fp32_t;

  // result word, read as float or as int32
  typedef union packed {
    fp32_t       f;
    logic [31:0] i;
  } result_u;

  typedef struct packed {
    logic ovf;
    logic unf;
    logic snf;
    logic qnf;
    logic zf;
    logic ixf;
    logic ivf;
    logic inf;
  } fpcsr_t;

endpackage

// File: fpu_rnd_align.sv
// stage 1 of the rounding back end: source select, align shift, sticky and exponent

`timescale 1ns/1ns
`include "fpu_rnd_macros.svh"

module fpu_rnd_align
  import fpu_rnd_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        adv_i,
  input  logic        flush_i,
  input  logic [1:0]  rmode_i,
  input  addsub_src_t add_i,
  input  mul_src_t    mul_i,
  input  f2i_src_t    f2i_i,
  output aligned_t    align_o,
  output logic        align_valid_o
);

  logic [`ALIGN_W-1:0] fract35;    // merged source word
  logic [`ALIGN_W-1:0] fract35_sh; // after align
  logic [`ALIGN_W-1:0] rmask;      // bits lost on right shift
  logic [`ALIGN_W-1:0] lmask;      // bits still below r on left shift
  logic [`SHIFT_W-1:0] shr_src;
  logic [`SHIFT_W-1:0] shr;
  logic [`SHIFT_W-1:0] shl;
  logic [`EXP_W-1:0]   exp_shr;
  logic [`EXP_W-1:0]   exp_shl;
  logic [`EXP_W-1:0]   exp_sh0;
  logic [`EXP_W-1:0]   exp_sel;
  logic                carry;
  logic                add_sign;
  logic                sticky;
  logic                any_ready;
  aligned_t            align_d;

  ////////////////////////////////////////////////////////////
  // source merge, at most one ready
  ////////////////////////////////////////////////////////////

  // exact zero: -0 only when rounding to -inf
  assign add_sign = add_i.sub_0 ? (rmode_i == `RM_TO_INFM) : add_i.sign;

  assign {align_d.sign, align_d.inv, align_d.inf, align_d.snan, align_d.qnan,
          align_d.anan_sign} =
    ({6{add_i.ready}} & {add_sign, add_i.inv, add_i.inf, add_i.snan, add_i.qnan,
                         add_i.anan_sign}) |
    ({6{mul_i.ready}} & {mul_i.sign, mul_i.inv, mul_i.inf, mul_i.snan, mul_i.qnan,
                         mul_i.anan_sign}) |
    ({6{f2i_i.ready}} & {f2i_i.sign, 2'b00, f2i_i.snan, 1'b0, f2i_i.sign});

  assign fract35 =
    ({`ALIGN_W{add_i.ready}} & {{(`ALIGN_W-`FRACT_W){1'b0}}, add_i.fract}) |
    ({`ALIGN_W{mul_i.ready}} & {{(`ALIGN_W-`FRACT_W){1'b0}}, mul_i.fract}) |
    ({`ALIGN_W{f2i_i.ready}} & {8'd0, f2i_i.int24, 3'd0}); // int lsb at guard

  assign carry = (add_i.ready & add_i.fract[`FRACT_W-1]) |
                 (mul_i.ready & mul_i.fract[`FRACT_W-1]);

  assign {shr_src, shl} =
    ({(2*`SHIFT_W){add_i.ready}} & {{`SHIFT_W{1'b0}}, add_i.shl}) |
    ({(2*`SHIFT_W){mul_i.ready}} & {mul_i.shr, {(`SHIFT_W-1){1'b0}}, mul_i.shl}) |
    ({(2*`SHIFT_W){f2i_i.ready}} & {f2i_i.shr, 1'b0, f2i_i.shl});

  assign shr = (|shr_src) ? shr_src : {{(`SHIFT_W-1){1'b0}}, carry}; // carry forces shr 1

  ////////////////////////////////////////////////////////////
  // align and sticky
  ////////////////////////////////////////////////////////////

  assign fract35_sh = (|shr) ? (fract35 >> shr) : (fract35 << shl);

  // sticky covers r,s slots plus everything pushed out below them
  assign rmask  = ({{(`ALIGN_W-3){1'b0}}, 3'b100} << shr) - 1'b1;
  assign lmask  = {{(`ALIGN_W-2){1'b0}}, 2'b11} >> shl;
  assign sticky = |(fract35 & ((|shr) ? rmask : lmask));

  // exponent per shift case; add has no right shift of its own
  assign {exp_shr, exp_shl, exp_sh0} =
    ({(3*`EXP_W){add_i.ready}} & {add_i.exp_sh0, add_i.exp_shl, add_i.exp_sh0}) |
    ({(3*`EXP_W){mul_i.ready}} & {mul_i.exp_shr, mul_i.exp_shl, mul_i.exp_sh0});
    // f2i keeps exponent zero

  assign exp_sel = (|shr_src) ? exp_shr :
                   (~(|shl))  ? (exp_sh0 + {{(`EXP_W-1){1'b0}}, carry}) :
                                exp_shl;

  assign align_d.exp    = exp_sel;
  assign align_d.fract  = fract35_sh[`ALIGN_W-1:3];
  assign align_d.rs     = {fract35_sh[2], sticky};
  assign align_d.ovf    = f2i_i.ready & f2i_i.ovf;
  assign align_d.is_int = f2i_i.ready;

  assign any_ready = add_i.ready | mul_i.ready | f2i_i.ready;

  ////////////////////////////////////////////////////////////
  // stage register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (adv_i) begin
      align_o <= align_d; // payload, no reset
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      align_valid_o <= 1'b0;
    end else if (flush_i) begin
      align_valid_o <= 1'b0;
    end else if (adv_i) begin
      align_valid_o <= any_ready;
    end
  end

  // producers must not collide
  a_one_ready : assert property (@(posedge clk) disable iff (rst)
    $onehot0({add_i.ready, mul_i.ready, f2i_i.ready}));

endmodule

// File: fpu_rnd_round.sv
// stage 2 of the rounding back end: rounding decision and increment of the aligned fraction

`timescale 1ns/1ns
`include "fpu_rnd_macros.svh"

module fpu_rnd_round
  import fpu_rnd_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       adv_i,
  input  logic       flush_i,
  input  logic [1:0] rmode_i,
  input  aligned_t   align_i,
  input  logic       align_valid_i,
  output rounded_t   rnd_o,
  output logic       rnd_valid_o
);

  logic     g;      // lsb kept
  logic     r;
  logic     s;
  logic     lost;
  logic     rnd_up;
  rounded_t rnd_d;

  assign g    = align_i.fract[0];
  assign r    = align_i.rs[1];
  assign s    = align_i.rs[0];
  assign lost = r | s;

  ////////////////////////////////////////////////////////////
  // round up decision
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (rmode_i)
      `RM_NEAREST: rnd_up = (r & s) | (g & r);  // above half, or tie to even
      `RM_TO_ZERO: rnd_up = 1'b0;               // truncate
      `RM_TO_INFP: rnd_up = ~align_i.sign & lost;
      `RM_TO_INFM: rnd_up = align_i.sign & lost;
      default:     rnd_up = 1'b0;
    endcase
  end

  assign rnd_d.sign      = align_i.sign;
  assign rnd_d.exp       = align_i.exp;
  assign rnd_d.fract     = align_i.fract + {31'd0, rnd_up}; // may carry into bit 24
  assign rnd_d.lost      = lost;
  assign rnd_d.inv       = align_i.inv;
  assign rnd_d.inf       = align_i.inf;
  assign rnd_d.snan      = align_i.snan;
  assign rnd_d.qnan      = align_i.qnan;
  assign rnd_d.anan_sign = align_i.anan_sign;
  assign rnd_d.ovf       = align_i.ovf;
  assign rnd_d.is_int    = align_i.is_int;

  ////////////////////////////////////////////////////////////
  // stage register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (adv_i) begin
      rnd_o <= rnd_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rnd_valid_o <= 1'b0;
    end else if (flush_i) begin
      rnd_valid_o <= 1'b0;
    end else if (adv_i) begin
      rnd_valid_o <= align_valid_i;
    end
  end

  // valid chain stays defined from stage 1 onward
  a_valid_known : assert property (@(posedge clk) disable iff (rst)
    !$isunknown({align_valid_i, rnd_valid_o}));

endmodule

// File: fpu_rnd_finish.sv
// stage 3 of the rounding back end: float or int32 result, special values and flag word

`timescale 1ns/1ns
`include "fpu_rnd_macros.svh"

module fpu_rnd_finish
  import fpu_rnd_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     adv_i,
  input  logic     flush_i,
  input  rounded_t rnd_i,
  input  logic     rnd_valid_i,
  output result_u  result_o,
  output logic     valid_o,
  output fpcsr_t   fpcsr_o
);

  logic              f_shr;    // rounding carried into bit 24
  logic [`EXP_W-1:0] f_exp;
  logic [23:0]       f_fract24;
  logic              f_dn;     // hidden bit clear
  logic              f_zero;
  logic              f_ovf;    // finite float past the largest exponent
  logic              i_carry;
  logic              i_inv;    // saturate
  logic [31:0]       i_int32;
  logic              i_zero;
  result_u           res_d;
  fpcsr_t            csr_d;

  ////////////////////////////////////////////////////////////
  // float path
  ////////////////////////////////////////////////////////////

  assign f_shr     = rnd_i.fract[24];
  assign f_exp     = rnd_i.exp + {{(`EXP_W-1){1'b0}}, f_shr};
  assign f_fract24 = f_shr ? rnd_i.fract[24:1] : rnd_i.fract[23:0];
  assign f_dn      = ~f_fract24[23];
  assign f_zero    = ~(|f_fract24);

  // overflow flag decoded on its own, apart from the result mux
  assign f_ovf = (f_exp > `EXP_MAX) & ~rnd_i.inf & ~rnd_i.is_int & ~rnd_i.inv &
                 ~(rnd_i.snan | rnd_i.qnan);

  ////////////////////////////////////////////////////////////
  // int32 path
  ////////////////////////////////////////////////////////////

  assign i_carry = rnd_i.fract[31];
  assign i_inv   = (~rnd_i.sign & i_carry) | rnd_i.ovf;
  assign i_int32 = (rnd_i.fract ^ {32{rnd_i.sign}}) + {31'd0, rnd_i.sign}; // 2's compl
  assign i_zero  = ~i_inv & ~(|i_int32);

  ////////////////////////////////////////////////////////////
  // result and flags by priority
  ////////////////////////////////////////////////////////////

  always_comb begin
    res_d.i   = 32'd0;
    csr_d     = '0;
    csr_d.snf = rnd_i.inv | (rnd_i.snan & rnd_i.is_int);
    csr_d.qnf = rnd_i.qnan;
    csr_d.ivf = rnd_i.inv | (i_inv & rnd_i.is_int) | rnd_i.snan;
    csr_d.ovf = f_ovf;
    if (rnd_i.is_int) begin
      res_d.i   = i_inv ? (32'h7fff_ffff ^ {32{rnd_i.sign}}) : i_int32;
      csr_d.ixf = rnd_i.lost;
      csr_d.zf  = i_zero;
    end else if (rnd_i.snan | rnd_i.qnan) begin
      res_d.i = {rnd_i.anan_sign, `QNAN_BITS}; // no ixf on NaN
    end else if (rnd_i.inv) begin
      res_d.i = {rnd_i.sign, `SNAN_BITS};
    end else if ((f_exp > `EXP_MAX) | rnd_i.inf) begin
      res_d.i   = {rnd_i.sign, `INF_BITS};
      csr_d.ixf = ~rnd_i.inf;  // overflow always inexact
      csr_d.inf = 1'b1;
    end else if (f_dn | f_zero) begin
      res_d.f.sign = rnd_i.sign;
      res_d.f.exp  = 8'd0;
      res_d.f.mant = f_fract24[22:0];
      csr_d.ixf    = rnd_i.lost;
      csr_d.unf    = rnd_i.lost; // tiny and inexact
      csr_d.zf     = f_zero;
    end else begin
      res_d.f.sign = rnd_i.sign;
      res_d.f.exp  = f_exp[7:0];
      res_d.f.mant = f_fract24[22:0]; // hidden bit dropped
      csr_d.ixf    = rnd_i.lost;
    end
  end

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      result_o <= '0;
      valid_o  <= 1'b0;
      fpcsr_o  <= '0;
    end else if (flush_i) begin
      result_o <= '0;
      valid_o  <= 1'b0;
      fpcsr_o  <= '0;
    end else if (adv_i) begin
      result_o <= res_d;
      valid_o  <= rnd_valid_i;
      fpcsr_o  <= csr_d;
    end
  end

  // overflow only ever comes with an infinity word and flag
  a_ovf_inf : assert property (@(posedge clk) disable iff (rst)
    fpcsr_o.ovf |-> (fpcsr_o.inf && result_o.f.exp == 8'hff && result_o.f.mant == 23'd0));

endmodule

// File: fpu_rnd.sv
// top of the FPU rounding back end; producers drive the source structs, host drives adv/flush

`timescale 1ns/1ns

module fpu_rnd
  import fpu_rnd_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        adv_i,    // level, low freezes all stages
  input  logic        flush_i,  // level, drops in-flight ops
  input  logic [1:0]  rmode_i,  // not pipelined
  input  addsub_src_t add_i,
  input  mul_src_t    mul_i,
  input  f2i_src_t    f2i_i,
  output result_u     result_o,
  output logic        valid_o,
  output fpcsr_t      fpcsr_o
);

  aligned_t align_w;
  logic     align_valid;
  rounded_t rnd_w;
  logic     rnd_valid;

  // stage 1, align
  fpu_rnd_align align_i (
    .clk           (clk),
    .rst           (rst),
    .adv_i         (adv_i),
    .flush_i       (flush_i),
    .rmode_i       (rmode_i),
    .add_i         (add_i),
    .mul_i         (mul_i),
    .f2i_i         (f2i_i),
    .align_o       (align_w),
    .align_valid_o (align_valid)
  );

  // stage 2, round
  fpu_rnd_round round_i (
    .clk           (clk),
    .rst           (rst),
    .adv_i         (adv_i),
    .flush_i       (flush_i),
    .rmode_i       (rmode_i),
    .align_i       (align_w),
    .align_valid_i (align_valid),
    .rnd_o         (rnd_w),
    .rnd_valid_o   (rnd_valid)
  );

  // stage 3, finish and output register
  fpu_rnd_finish finish_i (
    .clk         (clk),
    .rst         (rst),
    .adv_i       (adv_i),
    .flush_i     (flush_i),
    .rnd_i       (rnd_w),
    .rnd_valid_i (rnd_valid),
    .result_o    (result_o),
    .valid_o     (valid_o),
    .fpcsr_o     (fpcsr_o)
  );

endmodule

// File: tb_clk_gen.sv
// testbench clock and reset source, 4 ns period with reset held for the first 8 cycles

`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0; // released just after the 8th edge
  end

  always #2 clk = ~clk; // 4 ns period

endmodule

// File: tb_fpu_rnd.sv
// testbench for the rounding back end; runs a table of operations and pipeline control checks

`timescale 1ns/1ns
`include "fpu_rnd_macros.svh"

module tb_fpu_rnd
  import fpu_rnd_pkg::*;
();

  typedef struct {
    logic [1:0]  rm;
    logic        rnd;      // randomize add fraction, don't care
    addsub_src_t add;
    mul_src_t    mul;
    f2i_src_t    f2i;
    logic [31:0] res;
    logic [7:0]  csr;      // {ovf,unf,snf,qnf,zf,ixf,ivf,inf}
  } test_t;

  logic        clk;
  logic        rst;
  logic        adv_i;
  logic        flush_i;
  logic [1:0]  rmode_i;
  addsub_src_t add_i;
  mul_src_t    mul_i;
  f2i_src_t    f2i_i;
  result_u     result_o;
  logic        valid_o;
  fpcsr_t      fpcsr_o;

  test_t       tbl[$];
  string       names[$];
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          cycles   = 0;
  int          limit    = 1000; // replaced once the table is built
  bit          ok;

  tb_clk_gen clk_gen_i (.clk(clk), .rst(rst));

  fpu_rnd fpu_rnd_i (
    .clk      (clk),
    .rst      (rst),
    .adv_i    (adv_i),
    .flush_i  (flush_i),
    .rmode_i  (rmode_i),
    .add_i    (add_i),
    .mul_i    (mul_i),
    .f2i_i    (f2i_i),
    .result_o (result_o),
    .valid_o  (valid_o),
    .fpcsr_o  (fpcsr_o)
  );

  ////////////////////////////////////////////////////////////
  // table builders, one per source kind
  ////////////////////////////////////////////////////////////

  task automatic add_row(input string nm, input logic [1:0] rm, input logic sign,
                         input logic sub_0, input logic [9:0] e0, input logic [27:0] fract,
                         input logic [4:0] flg, input logic rnd, input logic [31:0] res,
                         input logic [7:0] csr);
    test_t t;
    t.add = '0;
    t.mul = '0;
    t.f2i = '0;
    t.add.ready = 1'b1;
    t.add.sign  = sign;
    t.add.sub_0 = sub_0;
    t.add.exp_shl = 10'd300; // no left shift here, a wrong pick overflows
    t.add.exp_sh0 = e0;
    t.add.fract = fract;
    {t.add.inv, t.add.inf, t.add.snan, t.add.qnan, t.add.anan_sign} = flg;
    t.rm  = rm;
    t.rnd = rnd;
    t.res = res;
    t.csr = csr;
    tbl.push_back(t);
    names.push_back(nm);
  endtask

  task automatic mul_row(input string nm, input logic [1:0] rm, input logic sign,
                         input logic [4:0] shr, input logic shl, input logic [9:0] e,
                         input logic [27:0] fract, input logic [31:0] res,
                         input logic [7:0] csr);
    test_t t;
    t.add = '0;
    t.mul = '0;
    t.f2i = '0;
    t.mul.ready = 1'b1;
    t.mul.sign  = sign;
    t.mul.shr   = shr;
    t.mul.shl   = shl;
    // only the exponent of the active shift case is in range
    t.mul.exp_shr = (shr != 0) ? e : 10'd300;
    t.mul.exp_shl = (shr == 0 && shl) ? e : 10'd300;
    t.mul.exp_sh0 = (shr == 0 && !shl) ? e : 10'd300;
    t.mul.fract = fract;
    t.rm  = rm;
    t.rnd = 1'b0;
    t.res = res;
    t.csr = csr;
    tbl.push_back(t);
    names.push_back(nm);
  endtask

  task automatic f2i_row(input string nm, input logic [1:0] rm, input logic sign,
                         input logic [23:0] int24, input logic [4:0] shr, input logic [3:0] shl,
                         input logic ovf, input logic snan, input logic [31:0] res,
                         input logic [7:0] csr);
    test_t t;
    t.add = '0;
    t.mul = '0;
    t.f2i = '0;
    t.f2i.ready = 1'b1;
    t.f2i.sign  = sign;
    t.f2i.int24 = int24;
    t.f2i.shr   = shr;
    t.f2i.shl   = shl;
    t.f2i.ovf   = ovf;
    t.f2i.snan  = snan;
    t.rm  = rm;
    t.rnd = 1'b0;
    t.res = res;
    t.csr = csr;
    tbl.push_back(t);
    names.push_back(nm);
  endtask

  task automatic build_table();
    // add, nearest even; hidden bit at 26, r at 2
    add_row("add tie down", `RM_NEAREST, 0, 0, 10'd127, 28'h400_0004, 5'b0, 0,
            32'h3f80_0000, 8'h04);
    add_row("add tie up", `RM_NEAREST, 0, 0, 10'd127, 28'h400_000c, 5'b0, 0,
            32'h3f80_0002, 8'h04);
    add_row("add round up", `RM_NEAREST, 0, 0, 10'd127, 28'h400_0005, 5'b0, 0,
            32'h3f80_0001, 8'h04);
    add_row("add renormalize", `RM_NEAREST, 0, 0, 10'd127, 28'h7ff_ffff, 5'b0, 0,
            32'h4000_0000, 8'h04);
    add_row("add carry exact", `RM_NEAREST, 0, 0, 10'd127, 28'h800_0000, 5'b0, 0,
            32'h4000_0000, 8'h00);
    // mul, shr 2 gives a denormal with r and sticky set
    mul_row("mul shr nearest", `RM_NEAREST, 0, 5'd2, 0, 10'd0, 28'h400_0014,
            32'h0020_0001, 8'h44);
    mul_row("mul shr to zero", `RM_TO_ZERO, 0, 5'd2, 0, 10'd0, 28'h400_0014,
            32'h0020_0000, 8'h44);
    mul_row("mul shr to +inf", `RM_TO_INFP, 0, 5'd2, 0, 10'd0, 28'h400_0014,
            32'h0020_0001, 8'h44);
    mul_row("mul shr to -inf", `RM_TO_INFM, 1, 5'd2, 0, 10'd0, 28'h400_0014,
            32'h8020_0001, 8'h44);
    mul_row("mul shl", `RM_NEAREST, 0, 5'd0, 1, 10'd100, 28'h200_0000,
            32'h3200_0000, 8'h00);
    mul_row("mul exact", `RM_TO_INFP, 0, 5'd0, 0, 10'd130, 28'h480_0000,
            32'h4110_0000, 8'h00);
    // specials, flags {inv,inf,snan,qnan,anan_sign}
    add_row("qnan in", `RM_NEAREST, 0, 0, 10'd127, 28'h0, 5'b00011, 1,
            32'hffc0_0000, 8'h10);
    add_row("snan in", `RM_NEAREST, 0, 0, 10'd127, 28'h0, 5'b00100, 1,
            32'h7fc0_0000, 8'h02);
    add_row("invalid", `RM_NEAREST, 0, 0, 10'd127, 28'h0, 5'b10000, 1,
            32'h7fbf_ffff, 8'h22);
    add_row("inf in", `RM_NEAREST, 1, 0, 10'd127, 28'h0, 5'b01000, 1,
            32'hff80_0000, 8'h01);
    add_row("exp overflow", `RM_NEAREST, 0, 0, 10'd255, 28'h400_0000, 5'b0, 0,
            32'h7f80_0000, 8'h85);
    // exact zero subtraction, input sign is overridden
    add_row("sub zero nearest", `RM_NEAREST, 1, 1, 10'd0, 28'h0, 5'b0, 0,
            32'h0000_0000, 8'h08);
    add_row("sub zero to zero", `RM_TO_ZERO, 1, 1, 10'd0, 28'h0, 5'b0, 0,
            32'h0000_0000, 8'h08);
    add_row("sub zero to -inf", `RM_TO_INFM, 0, 1, 10'd0, 28'h0, 5'b0, 0,
            32'h8000_0000, 8'h08);
    add_row("add underflow", `RM_TO_ZERO, 0, 0, 10'd0, 28'h000_0014, 5'b0, 0,
            32'h0000_0002, 8'h44);
    // float to int32
    f2i_row("f2i positive", `RM_NEAREST, 0, 24'h0004d2, 5'd0, 4'd0, 0, 0,
            32'h0000_04d2, 8'h00);
    f2i_row("f2i negative", `RM_NEAREST, 1, 24'h000005, 5'd0, 4'd0, 0, 0,
            32'hffff_fffb, 8'h00);
    f2i_row("f2i shr round", `RM_NEAREST, 0, 24'h00000b, 5'd2, 4'd0, 0, 0,
            32'h0000_0003, 8'h04); // 2.75 rounds to 3
    f2i_row("f2i shl", `RM_TO_ZERO, 0, 24'h123456, 5'd0, 4'd8, 0, 0,
            32'h1234_5600, 8'h00);
    f2i_row("f2i ovf pos", `RM_NEAREST, 0, 24'h0, 5'd0, 4'd0, 1, 0,
            32'h7fff_ffff, 8'h02);
    f2i_row("f2i ovf neg", `RM_NEAREST, 1, 24'h0, 5'd0, 4'd0, 1, 0,
            32'h8000_0000, 8'h02);
    f2i_row("f2i carry sat", `RM_NEAREST, 0, 24'h800000, 5'd0, 4'd8, 0, 0,
            32'h7fff_ffff, 8'h02);
    f2i_row("f2i snan", `RM_NEAREST, 0, 24'h0, 5'd0, 4'd0, 0, 1,
            32'h0000_0000, 8'h2a);
  endtask

  ////////////////////////////////////////////////////////////
  // drive, wait and compare
  ////////////////////////////////////////////////////////////

  task automatic clear_sources();
    add_i = '0;
    mul_i = '0;
    f2i_i = '0;
  endtask

  task automatic simple_add();
    clear_sources();
    add_i.ready   = 1'b1;
    add_i.exp_sh0 = 10'd127;
    add_i.fract   = 28'h400_0000; // 1.0
  endtask

  // polls valid_o once per edge, gives up after 8 edges
  task automatic wait_valid(output bit seen, output int edges);
    seen  = 0;
    edges = 0;
    while (!seen && edges < 8) begin
      @(posedge clk);
      #1;
      edges++;
      if (valid_o) seen = 1;
    end
  endtask

  task automatic compare(input logic [31:0] res, input logic [7:0] csr);
    assert (result_o.i === res) else begin
      $display("FAIL t=%0t result_o got %h expected %h", $time, result_o.i, res);
      ok = 0;
    end
    assert (fpcsr_o === csr) else begin
      $display("FAIL t=%0t fpcsr_o got %h expected %h", $time, fpcsr_o, csr);
      ok = 0;
    end
  endtask

  task automatic report(input string nm);
    if (ok) pass_cnt++;
    else fail_cnt++;
    $display("test %-18s %s", nm, ok ? "ok" : "FAILED");
  endtask

  task automatic freeze_test();
    logic [31:0] held;
    bit          seen;
    int          edges;
    ok = 1;
    simple_add();
    @(posedge clk);
    #1;
    clear_sources();
    adv_i = 1'b0;
    held  = result_o.i;
    repeat (5) begin
      @(posedge clk);
      #1;
      assert (valid_o === 1'b0) else begin
        $display("FAIL t=%0t valid_o got %b expected 0 while frozen", $time, valid_o);
        ok = 0;
      end
      assert (result_o.i === held) else begin
        $display("FAIL t=%0t result_o got %h expected %h while frozen", $time,
                 result_o.i, held);
        ok = 0;
      end
    end
    adv_i = 1'b1;
    wait_valid(seen, edges);
    assert (seen && edges == 2) else begin
      $display("result did not appear on the third advancing edge");
      ok = 0;
    end
    compare(32'h3f80_0000, 8'h00);
    report("adv freeze");
  endtask

  task automatic flush_test();
    ok = 1;
    simple_add();
    @(posedge clk);
    #1;
    simple_add(); // second op right behind
    @(posedge clk);
    #1;
    clear_sources();
    flush_i = 1'b1;
    @(posedge clk);
    #1;
    flush_i = 1'b0;
    compare(32'h0, 8'h00); // outputs cleared
    repeat (5) begin
      assert (valid_o === 1'b0) else begin
        $display("FAIL t=%0t valid_o got %b expected 0", $time, valid_o);
        ok = 0;
      end
      @(posedge clk);
      #1;
    end
    report("flush");
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    test_t       t;
    logic [31:0] r;
    bit          seen;
    int          edges;
    adv_i   = 1'b1;
    flush_i = 1'b0;
    rmode_i = `RM_NEAREST;
    clear_sources();
    r = $urandom(32'h3f89_fe84); // seeds the generator
    build_table();
    limit = (tbl.size() + 20) * 4;
    @(negedge rst);
    @(posedge clk);
    #1;
    for (int i = 0; i < tbl.size(); i++) begin
      t  = tbl[i];
      ok = 1;
      if (t.rnd) begin
        r = $urandom;
        t.add.fract = r[27:0];
      end
      rmode_i = t.rm; // held until the result is out
      add_i   = t.add;
      mul_i   = t.mul;
      f2i_i   = t.f2i;
      @(posedge clk);
      #1;
      clear_sources();
      wait_valid(seen, edges);
      assert (seen && edges == 2) else begin
        $display("valid_o did not come 3 cycles after issue for %s", names[i]);
        ok = 0;
      end
      compare(t.res, t.csr);
      report(names[i]);
    end
    rmode_i = `RM_NEAREST;
    freeze_test();
    flush_test();
    $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // run limit in cycles
  always @(posedge clk) begin
    cycles++;
    if (cycles >= limit) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("Test failures found");
      $finish;
    end
  end

endmodule

// File: list.f
+incdir+.
fpu_rnd_pkg.sv
fpu_rnd_align.sv
fpu_rnd_round.sv
fpu_rnd_finish.sv
fpu_rnd.sv
tb_clk_gen.sv
tb_fpu_rnd.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, result decided from sim.log
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module tb_fpu_rnd -o tb_sim \
  > sim.log 2>&1 \
  && ./obj_dir/tb_sim >> sim.log 2>&1 \
  || echo "Test failures found" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0
